// File: project.f
cache_pkg.sv
cache_line_ram.sv
cache_tag_store.sv
cache_data_path.sv
cache_miss_fsm.sv
cache_top.sv
tb_mem_model.sv
tb_cache_top.sv

// File: Bender.yml
package:
  name: cache

sources:
  - cache_pkg.sv
  - cache_line_ram.sv
  - cache_tag_store.sv
  - cache_data_path.sv
  - cache_miss_fsm.sv
  - cache_top.sv
  - target: test
    files:
      - tb_mem_model.sv
      - tb_cache_top.sv

// File: tb_cache_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cache_top;

    localparam int          NUM_SETS   = 128;
    localparam int          CLK_PERIOD = 40;
    localparam int          RST_CYCLES = 10;
    localparam int          ACCEPT_DLY = 3;
    localparam int          FILL_DLY   = 2;
    localparam logic [31:0] FLIP       = 32'hc3a5_5a3c;
    localparam logic [31:0] TAG_STRIDE = NUM_SETS * 32;
    // one access that misses, plus slack
    localparam int          OP_CYCLES  = ACCEPT_DLY + FILL_DLY + 10;
    localparam int          RAND_OPS   = 200;
    localparam int          NUM_OPS    = RAND_OPS + 40;

    logic                 clk = 1'b0;
    logic                 rst;
    cache_pkg::cpu_req_t  req;
    cache_pkg::word_t     rdata;
    logic                 stall;
    logic                 rd_req;
    logic [31:0]          rd_addr;
    logic                 rd_accept;
    logic                 fill;
    cache_pkg::line_t     fill_line;
    logic                 wb_valid;
    cache_pkg::mem_wb_t   wb;

    // what the cpu should read back, by word address
    cache_pkg::word_t     shadow [logic [31:0]];
    logic [31:0]          rng = 32'h46e2;
    int                   refill_count = 0;
    int                   wb_count = 0;
    logic                 rd_req_q = 1'b0;
    logic [31:0]          last_rd_addr;
    cache_pkg::mem_wb_t   last_wb;

    cache_top #(.NUM_SETS(NUM_SETS)) dut (
        .clk         (clk),
        .rst         (rst),
        .req_i       (req),
        .rdata_o     (rdata),
        .stall_o     (stall),
        .rd_req_o    (rd_req),
        .rd_addr_o   (rd_addr),
        .rd_accept_i (rd_accept),
        .fill_i      (fill),
        .fill_line_i (fill_line),
        .wb_valid_o  (wb_valid),
        .wb_o        (wb)
    );

    tb_mem_model #(.ACCEPT_DLY(ACCEPT_DLY), .FILL_DLY(FILL_DLY), .FLIP(FLIP)) u_mem (
        .clk         (clk),
        .rst         (rst),
        .rd_req_i    (rd_req),
        .rd_addr_i   (rd_addr),
        .rd_accept_o (rd_accept),
        .fill_o      (fill),
        .fill_line_o (fill_line),
        .wb_valid_i  (wb_valid),
        .wb_i        (wb)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((NUM_OPS * OP_CYCLES + RST_CYCLES) * CLK_PERIOD);
        $display("Timeout: the cache tests did not finish in the expected time");
        $display("Regression failed");
        $fatal(1, "watchdog expired");
    end

    // count refill requests and write-back pulses
    always @(negedge clk) begin
        rd_req_q <= rd_req;
        if (!rst && rd_req && !rd_req_q) begin
            refill_count <= refill_count + 1;
            last_rd_addr <= rd_addr;
        end
        if (!rst && wb_valid) begin
            wb_count <= wb_count + 1;
            last_wb  <= wb;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] addr_of(input int tag, input int set, input int off);
        return 32'(tag) * TAG_STRIDE + 32'(set * 32) + 32'(off * 4);
    endfunction

    function automatic cache_pkg::word_t expected_word(input logic [31:0] addr);
        logic [31:0] word_addr;
        word_addr = {addr[31:2], 2'b00};
        if (shadow.exists(word_addr)) begin
            return shadow[word_addr];
        end
        return word_addr ^ FLIP;
    endfunction

    function automatic void shadow_write(input logic [31:0] addr, input cache_pkg::be_t be,
                                         input cache_pkg::word_t data);
        cache_pkg::word_t w;
        w = expected_word(addr);
        for (int b = 0; b < cache_pkg::BE_W; b++) begin
            if (be[b]) begin
                w[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        shadow[{addr[31:2], 2'b00}] = w;
    endfunction

    task automatic halt_failed();
        $display("Regression failed");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_value(input string test, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("Error: %s expected %h actual %h", test, exp, act);
            halt_failed();
        end
    endtask

    // one cpu request, held while stalled; returns the word of the cycle after the hit
    task automatic cpu_access(input logic [31:0] addr, input cache_pkg::be_t be,
                              input cache_pkg::word_t data,
                              output cache_pkg::word_t got, output logic missed);
        int waited;
        @(negedge clk);
        req.en    = 1'b1;
        req.be    = be;
        req.addr  = addr;
        req.wdata = data;
        #(CLK_PERIOD / 4);
        missed = stall;
        waited = 0;
        while (stall) begin
            @(negedge clk);
            #(CLK_PERIOD / 4);
            waited++;
            if (waited > OP_CYCLES) begin
                $display("stall_o stayed high too long on a miss to address %h", addr);
                halt_failed();
            end
        end
        @(negedge clk);
        got = rdata;
        req = '0;
    endtask

    task automatic read_check(input string test, input logic [31:0] addr,
                              output logic missed);
        cache_pkg::word_t got;
        cpu_access(addr, 4'b0000, '0, got, missed);
        check_value(test, expected_word(addr), got);
    endtask

    task automatic write_word(input logic [31:0] addr, input cache_pkg::be_t be,
                              input cache_pkg::word_t data, output logic missed);
        cache_pkg::word_t got;
        cpu_access(addr, be, data, got, missed);
        shadow_write(addr, be, data);
    endtask

    task automatic test_reset_idle();
        repeat (3) begin
            @(negedge clk);
            check_value("reset_idle stall_o", 32'd0, stall);
            check_value("reset_idle rd_req_o", 32'd0, rd_req);
            check_value("reset_idle wb_valid_o", 32'd0, wb_valid);
        end
    endtask

    task automatic test_read_miss();
        logic        missed;
        int          refills;
        logic [31:0] a;
        a = addr_of(1, 3, 5);
        refills = refill_count;
        read_check("read_miss rdata", a, missed);
        check_value("read_miss stall_o", 32'd1, missed);
        check_value("read_miss refills", refills + 1, refill_count);
        check_value("read_miss rd_addr_o", {a[31:5], 5'b0}, last_rd_addr);
    endtask

    task automatic test_write_hit();
        logic        missed;
        logic [31:0] a;
        a = addr_of(1, 3, 5);
        write_word(a, 4'b0101, 32'hdead_beef, missed);
        check_value("write_hit write miss", 32'd0, missed);
        read_check("write_hit rdata", a, missed);
        check_value("write_hit read miss", 32'd0, missed);
    endtask

    task automatic test_lru_replace();
        logic missed;
        int   refills;
        read_check("lru_replace rdata", addr_of(1, 10, 0), missed);
        read_check("lru_replace rdata", addr_of(2, 10, 1), missed);
        // touch A so B becomes the victim
        read_check("lru_replace rdata", addr_of(1, 10, 2), missed);
        check_value("lru_replace touch A", 32'd0, missed);
        read_check("lru_replace rdata", addr_of(3, 10, 3), missed);
        refills = refill_count;
        read_check("lru_replace rdata", addr_of(1, 10, 4), missed);
        check_value("lru_replace A kept", refills, refill_count);
        read_check("lru_replace rdata", addr_of(2, 10, 5), missed);
        check_value("lru_replace B evicted", refills + 1, refill_count);
    endtask

    task automatic test_write_back();
        logic        missed;
        int          wbs;
        logic [31:0] d;
        logic [31:0] line;
        d = addr_of(1, 20, 2);
        line = {d[31:5], 5'b0};
        read_check("write_back rdata", d, missed);
        write_word(d, 4'b1100, 32'h1234_5678, missed);
        wbs = wb_count;
        read_check("write_back rdata", addr_of(2, 20, 0), missed);
        check_value("write_back empty victim", wbs, wb_count);
        // dirty D is the victim now
        read_check("write_back rdata", addr_of(3, 20, 7), missed);
        check_value("write_back pulses", wbs + 1, wb_count);
        check_value("write_back addr", line, last_wb.addr);
        for (int w = 0; w < cache_pkg::LINE_WORDS; w++) begin
            check_value("write_back data", expected_word(line + 32'(w * 4)),
                        last_wb.data[w*32 +: 32]);
        end
        read_check("write_back rdata", addr_of(4, 20, 1), missed);
        check_value("write_back clean victim", wbs + 1, wb_count);
        read_check("write_back round trip", d, missed);
        check_value("write_back refetch miss", 32'd1, missed);
    endtask

    task automatic test_random_mix();
        logic             missed;
        logic [31:0]      a;
        cache_pkg::be_t   be;
        for (int i = 0; i < RAND_OPS; i++) begin
            rng = xorshift32(rng);
            a = addr_of(int'(rng[1:0]) + 8, int'(rng[3:2]) + 40, int'(rng[6:4]));
            if (rng[7]) begin
                be = (rng[11:8] == 4'b0000) ? 4'b1111 : rng[11:8];
                rng = xorshift32(rng);
                write_word(a, be, rng, missed);
            end else begin
                read_check("random_mix rdata", a, missed);
            end
        end
    endtask

    initial begin
        rst = 1'b1;
        req = '0;
        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b0;
        test_reset_idle();
        test_read_miss();
        test_write_hit();
        test_lru_replace();
        test_write_back();
        test_random_mix();
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mem_model #(
    parameter int          ACCEPT_DLY = 3,
    parameter int          FILL_DLY   = 2,
    parameter logic [31:0] FLIP       = 32'hc3a5_5a3c
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               rd_req_i,
    input  logic [31:0]        rd_addr_i,
    output logic               rd_accept_o,
    output logic               fill_o,
    output cache_pkg::line_t   fill_line_o,
    input  logic               wb_valid_i,
    input  cache_pkg::mem_wb_t wb_i
);

    // lines that came back from the cache, by line address
    cache_pkg::line_t lines [logic [31:0]];

    function automatic cache_pkg::line_t line_at(input logic [31:0] line_addr);
        cache_pkg::line_t line;
        logic [31:0]      word_addr;
        if (lines.exists(line_addr)) begin
            return lines[line_addr];
        end
        // untouched memory is the word address with a few bits flipped
        for (int w = 0; w < cache_pkg::LINE_WORDS; w++) begin
            word_addr = line_addr + 32'(w * 4);
            line[w*32 +: 32] = word_addr ^ FLIP;
        end
        return line;
    endfunction

    initial begin
        logic [31:0] addr;
        rd_accept_o = 1'b0;
        fill_o      = 1'b0;
        fill_line_o = '0;
        forever begin
            @(negedge clk);
            if (!rst && rd_req_i) begin
                addr = rd_addr_i;
                repeat (ACCEPT_DLY) @(negedge clk);
                rd_accept_o = 1'b1;
                @(negedge clk);
                rd_accept_o = 1'b0;
                repeat (FILL_DLY) @(negedge clk);
                fill_line_o = line_at(addr);
                fill_o      = 1'b1;
                @(negedge clk);
                fill_o = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (!rst && wb_valid_i) begin
            lines[wb_i.addr] = wb_i.data;
        end
    end

endmodule

`default_nettype wire

// File: cache_top.sv
`timescale 1ns/1ns
`default_nettype none

module cache_top #(
    parameter int NUM_SETS = 128
) (
    input  logic                         clk,
    input  logic                         rst,
    input  cache_pkg::cpu_req_t          req_i,
    output cache_pkg::word_t             rdata_o,
    output logic                         stall_o,
    output logic                         rd_req_o,
    output logic [cache_pkg::ADDR_W-1:0] rd_addr_o,
    input  logic                         rd_accept_i,
    input  logic                         fill_i,
    input  cache_pkg::line_t             fill_line_i,
    output logic                         wb_valid_o,
    output cache_pkg::mem_wb_t           wb_o
);

    localparam int IDX_W      = $clog2(NUM_SETS);
    localparam int LINE_OFF_W = cache_pkg::OFFSET_W + cache_pkg::BYTE_OFF_W;
    localparam int TAG_W      = cache_pkg::ADDR_W - IDX_W - LINE_OFF_W;

    // address split: tag | index | word offset | byte offset
    logic [TAG_W-1:0]               tag;
    logic [IDX_W-1:0]               index;
    logic [cache_pkg::OFFSET_W-1:0] offset;
    logic [cache_pkg::ADDR_W-1:0]   line_addr;

    logic [1:0]       hit;
    logic             miss;
    logic             victim_way;
    logic             victim_dirty;
    logic [TAG_W-1:0] victim_tag;
    logic             evict;

    assign tag       = req_i.addr[cache_pkg::ADDR_W-1 -: TAG_W];
    assign index     = req_i.addr[LINE_OFF_W +: IDX_W];
    assign offset    = req_i.addr[cache_pkg::BYTE_OFF_W +: cache_pkg::OFFSET_W];
    assign line_addr = {req_i.addr[cache_pkg::ADDR_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};

    // stall straight from the tag compare
    assign stall_o = miss;

    cache_tag_store #(.NUM_SETS(NUM_SETS)) u_tag_store (
        .clk            (clk),
        .rst            (rst),
        .en_i           (req_i.en),
        .write_i        (req_i.be != '0),
        .tag_i          (tag),
        .index_i        (index),
        .fill_i         (fill_i),
        .hit_o          (hit),
        .miss_o         (miss),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag)
    );

    cache_data_path #(.NUM_SETS(NUM_SETS)) u_data_path (
        .clk          (clk),
        .rst          (rst),
        .req_i        (req_i),
        .index_i      (index),
        .offset_i     (offset),
        .hit_i        (hit),
        .fill_i       (fill_i),
        .fill_line_i  (fill_line_i),
        .victim_way_i (victim_way),
        .victim_tag_i (victim_tag),
        .evict_i      (evict),
        .rdata_o      (rdata_o),
        .wb_valid_o   (wb_valid_o),
        .wb_o         (wb_o)
    );

    cache_miss_fsm u_miss_fsm (
        .clk            (clk),
        .rst            (rst),
        .miss_i         (miss),
        .line_addr_i    (line_addr),
        .victim_dirty_i (victim_dirty),
        .rd_accept_i    (rd_accept_i),
        .fill_i         (fill_i),
        .rd_req_o       (rd_req_o),
        .rd_addr_o      (rd_addr_o),
        .evict_o        (evict)
    );

endmodule

`default_nettype wire

// File: cache_miss_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module cache_miss_fsm (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         miss_i,
    input  logic [cache_pkg::ADDR_W-1:0] line_addr_i,
    input  logic                         victim_dirty_i,
    input  logic                         rd_accept_i,
    input  logic                         fill_i,
    output logic                         rd_req_o,
    output logic [cache_pkg::ADDR_W-1:0] rd_addr_o,
    output logic                         evict_o
);

    cache_pkg::miss_state_e state_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= cache_pkg::MISS_IDLE;
            rd_req_o  <= 1'b0;
            rd_addr_o <= '0;
            evict_o   <= 1'b0;
        end else begin
            // single cycle pulse
            evict_o <= 1'b0;
            case (state_q)
                cache_pkg::MISS_IDLE: begin
                    if (miss_i) begin
                        state_q   <= cache_pkg::MISS_REQ;
                        rd_req_o  <= 1'b1;
                        rd_addr_o <= line_addr_i;
                        evict_o   <= victim_dirty_i;
                    end
                end
                cache_pkg::MISS_REQ: begin
                    // hold until memory takes it
                    if (rd_accept_i) begin
                        state_q  <= cache_pkg::MISS_FILL;
                        rd_req_o <= 1'b0;
                    end
                end
                cache_pkg::MISS_FILL: begin
                    if (fill_i) begin
                        state_q <= cache_pkg::MISS_DONE;
                    end
                end
                cache_pkg::MISS_DONE: begin
                    // held request hits here and stall drops
                    state_q <= cache_pkg::MISS_IDLE;
                end
                default: begin
                    state_q  <= cache_pkg::MISS_IDLE;
                    rd_req_o <= 1'b0;
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        rd_req_o && !rd_accept_i |=> rd_req_o && $stable(rd_addr_o))
        else $error("refill request dropped or moved before accept");

endmodule

`default_nettype wire

// File: cache_data_path.sv
`timescale 1ns/1ns
`default_nettype none

module cache_data_path #(
    parameter int NUM_SETS = 128
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  cache_pkg::cpu_req_t                    req_i,
    input  logic [$clog2(NUM_SETS)-1:0]            index_i,
    input  logic [cache_pkg::OFFSET_W-1:0]         offset_i,
    input  logic [1:0]                             hit_i,
    input  logic                                   fill_i,
    input  cache_pkg::line_t                       fill_line_i,
    input  logic                                   victim_way_i,
    input  logic [cache_pkg::ADDR_W-$clog2(NUM_SETS)-cache_pkg::OFFSET_W
                  -cache_pkg::BYTE_OFF_W-1:0]      victim_tag_i,
    input  logic                                   evict_i,
    output cache_pkg::word_t                       rdata_o,
    output logic                                   wb_valid_o,
    output cache_pkg::mem_wb_t                     wb_o
);

    localparam int LINE_OFF_W = cache_pkg::OFFSET_W + cache_pkg::BYTE_OFF_W;

    cache_pkg::line_be_t way_we [2];
    cache_pkg::line_t    way_line [2];
    cache_pkg::line_t    wr_line;
    logic                ram_en;

    logic [cache_pkg::OFFSET_W-1:0] offset_q;
    logic [1:0]                     hit_q;

    // cpu word copied into every slot and the mask picks the lanes
    assign wr_line = fill_i ? fill_line_i : {cache_pkg::LINE_WORDS{req_i.wdata}};
    assign ram_en  = req_i.en || fill_i;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            if (fill_i && (victim_way_i == w[0])) begin
                way_we[w] = '1;
            end else if (req_i.en && (req_i.be != '0) && hit_i[w]) begin
                way_we[w] = cache_pkg::line_be_t'(req_i.be) << (offset_i * cache_pkg::BE_W);
            end else begin
                way_we[w] = '0;
            end
        end
    end

    for (genvar w = 0; w < 2; w++) begin : g_way
        cache_line_ram #(
            .NUM_SETS (NUM_SETS)
        ) u_ram (
            .clk     (clk),
            .en_i    (ram_en),
            .index_i (index_i),
            .we_i    (way_we[w]),
            .wdata_i (wr_line),
            .rdata_o (way_line[w])
        );
    end

    // lines up with the ram output
    always_ff @(posedge clk) begin
        if (rst) begin
            hit_q <= 2'b00;
        end else begin
            hit_q <= hit_i;
        end
    end

    always_ff @(posedge clk) begin
        offset_q <= offset_i;
    end

    always_comb begin
        if (hit_q[0]) begin
            rdata_o = way_line[0][offset_q*cache_pkg::WORD_W +: cache_pkg::WORD_W];
        end else if (hit_q[1]) begin
            rdata_o = way_line[1][offset_q*cache_pkg::WORD_W +: cache_pkg::WORD_W];
        end else begin
            rdata_o = '0;
        end
    end

    // victim line is on the ram output while the miss request is held
    always_ff @(posedge clk) begin
        if (evict_i) begin
            wb_o.addr <= {victim_tag_i, index_i, {LINE_OFF_W{1'b0}}};
            wb_o.data <= way_line[victim_way_i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= evict_i;
        end
    end

endmodule

`default_nettype wire

// File: cache_tag_store.sv
`timescale 1ns/1ns
`default_nettype none

module cache_tag_store #(
    parameter int NUM_SETS = 128
) (
    input  logic clk,
    input  logic rst,
    input  logic en_i,
    input  logic write_i,
    input  logic [cache_pkg::ADDR_W-$clog2(NUM_SETS)-cache_pkg::OFFSET_W
                  -cache_pkg::BYTE_OFF_W-1:0] tag_i,
    input  logic [$clog2(NUM_SETS)-1:0] index_i,
    input  logic fill_i,
    output logic [1:0] hit_o,
    output logic miss_o,
    output logic victim_way_o,
    output logic victim_dirty_o,
    output logic [cache_pkg::ADDR_W-$clog2(NUM_SETS)-cache_pkg::OFFSET_W
                  -cache_pkg::BYTE_OFF_W-1:0] victim_tag_o
);

    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = cache_pkg::ADDR_W - IDX_W - cache_pkg::OFFSET_W
                           - cache_pkg::BYTE_OFF_W;

    logic [TAG_W-1:0]    tag_q   [2][NUM_SETS];
    logic [NUM_SETS-1:0] valid_q [2];
    logic [NUM_SETS-1:0] dirty_q [2];
    // 0 means way 0 goes next
    logic [NUM_SETS-1:0] lru_q;

    logic victim;

    // tag compare per way
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            hit_o[w] = en_i && valid_q[w][index_i] && (tag_q[w][index_i] == tag_i);
        end
    end

    assign miss_o = en_i && (hit_o == 2'b00);

    assign victim         = lru_q[index_i];
    assign victim_way_o   = victim;
    assign victim_tag_o   = tag_q[victim][index_i];
    // clean or empty victims need no write-back
    assign victim_dirty_o = valid_q[victim][index_i] && dirty_q[victim][index_i];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < 2; w++) begin
                for (int s = 0; s < NUM_SETS; s++) begin
                    tag_q[w][s]   <= '0;
                    valid_q[w][s] <= 1'b0;
                    dirty_q[w][s] <= 1'b0;
                end
            end
            for (int s = 0; s < NUM_SETS; s++) begin
                lru_q[s] <= 1'b0;
            end
        end else if (fill_i) begin
            // new line lands in the victim way, clean
            tag_q[victim][index_i]   <= tag_i;
            valid_q[victim][index_i] <= 1'b1;
            dirty_q[victim][index_i] <= 1'b0;
            lru_q[index_i]           <= ~victim;
        end else if (hit_o != 2'b00) begin
            // point lru at the way not just used
            lru_q[index_i] <= hit_o[0];
            if (write_i) begin
                dirty_q[hit_o[1]][index_i] <= 1'b1;
            end
        end
    end

    // fills only go to a way that missed, so tags never alias
    assert property (@(posedge clk) disable iff (rst) !(hit_o[0] && hit_o[1]))
        else $error("both ways hit on the same set");

endmodule

`default_nettype wire

// File: cache_line_ram.sv
`timescale 1ns/1ns
`default_nettype none

module cache_line_ram #(
    parameter int NUM_SETS = 128
) (
    input  logic                       clk,
    input  logic                       en_i,
    input  logic [$clog2(NUM_SETS)-1:0] index_i,
    input  cache_pkg::line_be_t        we_i,
    input  cache_pkg::line_t           wdata_i,
    output cache_pkg::line_t           rdata_o
);

    localparam int IDX_W = $clog2(NUM_SETS);

    // one line per set, no reset on the array
    cache_pkg::line_t mem_q [NUM_SETS];

    logic [IDX_W-1:0] addr;

    assign addr = index_i;

    // read first: a write hit returns the old line this cycle
    always_ff @(posedge clk) begin
        if (en_i) begin
            for (int b = 0; b < cache_pkg::LINE_BE_W; b++) begin
                if (we_i[b]) begin
                    mem_q[addr][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
            rdata_o <= mem_q[addr];
        end
    end

endmodule

`default_nettype wire

// File: cache_pkg.sv
`default_nettype none

package cache_pkg;

    // cpu side
    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    localparam int BE_W       = WORD_W / 8;

    // line geometry
    localparam int LINE_WORDS = 8;
    localparam int OFFSET_W   = 3;
    localparam int BYTE_OFF_W = 2;
    localparam int LINE_W     = LINE_WORDS * WORD_W;
    localparam int LINE_BE_W  = LINE_W / 8;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [BE_W-1:0]      be_t;
    typedef logic [LINE_W-1:0]    line_t;
    typedef logic [LINE_BE_W-1:0] line_be_t;

    // be of zero is a read
    typedef struct packed {
        logic               en;
        be_t                be;
        logic [ADDR_W-1:0]  addr;
        word_t              wdata;
    } cpu_req_t;

    // victim line going back to memory, addr is line aligned
    typedef struct packed {
        logic [ADDR_W-1:0]  addr;
        line_t              data;
    } mem_wb_t;

    typedef enum logic [1:0] {
        MISS_IDLE = 2'd0,
        MISS_REQ  = 2'd1,
        MISS_FILL = 2'd2,
        MISS_DONE = 2'd3
    } miss_state_e;

endpackage

`default_nettype wire
